//--- all.f
mul_types_pkg.sv
mul_op_pkg.sv
booth_partial_product.sv
wallace_column.sv
mul_array.sv
mul_pipe.sv
mul_unit.sv
tb_mul_unit.sv

//--- booth_partial_product.sv
module booth_partial_product (
	input  logic [2:0]   digit,
	input  logic [131:0] multiplicand_row,
	output logic [131:0] row,
	output logic         neg
);

	logic [131:0] mag;

	// Overlapping triplet {b(2i+1), b(2i), b(2i-1)}
	always_comb begin
		case (digit)
			3'b001, 3'b010, 3'b101, 3'b110: mag = multiplicand_row;      // +1 and -1
			3'b011, 3'b100:                 mag = multiplicand_row << 1; // +2 and -2
			default:                        mag = '0;
		endcase
	end

	// 3'b111 is a zero digit and must not request the +1
	assign neg = digit[2] & ~(digit[1] & digit[0]);

	// Whole row inverted, low zeros included, so the +1 lands in column 0
	assign row = neg ? ~mag : mag;

endmodule

//--- mul_array.sv
module mul_array (
	input  logic [mul_types_pkg::XLEN-1:0] opa,
	input  logic [mul_types_pkg::XLEN-1:0] opb,
	input  logic                           signed_a,
	input  logic                           signed_b,
	input  logic                           word,
	output mul_types_pkg::mul_product_u    product
);

	import mul_types_pkg::*;

	logic [EXT_W-1:0]       a_ext;
	logic [EXT_W-1:0]       b_ext;
	logic [EXT_W:0]         a_pad;
	logic [PROD_W-1:0]      b_wide;
	logic [PROD_W-1:0]      pp [BOOTH_ROWS];
	logic [BOOTH_ROWS-1:0]  neg;
	logic [BOOTH_ROWS-1:0]  col_din [PROD_W];
	logic [COL_CARRIES-1:0] col_cin [PROD_W];
	logic [COL_CARRIES-1:0] col_cout [PROD_W-1];
	logic [PROD_W-2:0]      col_carry;
	logic [PROD_W-1:0]      col_sum;
	logic [PROD_W-1:0]      total;

	function automatic logic [EXT_W-1:0] extend(input logic [XLEN-1:0] v,
		input logic sgn, input logic wd);
		logic [XLEN-1:0] w;
		w = wd ? {{(XLEN/2){v[XLEN/2-1]}}, v[XLEN/2-1:0]} : v;
		return {{(EXT_W-XLEN){sgn & w[XLEN-1]}}, w};
	endfunction

	assign a_ext  = extend(opa, signed_a, word);
	assign b_ext  = extend(opb, signed_b, word);
	assign a_pad  = {a_ext, 1'b0};                  // Implicit b(-1) for the first digit
	assign b_wide = {{(PROD_W-EXT_W){b_ext[EXT_W-1]}}, b_ext};

	for (genvar r = 0; r < BOOTH_ROWS; r++) begin : g_row
		booth_partial_product i_booth (
			.digit           (a_pad[2*r+2:2*r]),
			.multiplicand_row(b_wide << (2*r)),
			.row             (pp[r]),
			.neg             (neg[r])
		);
	end

	// Corrections 0..30 ride in column 0 as its carry group
	assign col_cin[0] = neg[COL_CARRIES-1:0];

	for (genvar c = 0; c < PROD_W; c++) begin : g_col
		for (genvar r = 0; r < BOOTH_ROWS; r++) begin : g_bit
			assign col_din[c][r] = pp[r][c];
		end

		if (c > 0) begin : g_link
			assign col_cin[c] = col_cout[c-1];
		end

		if (c == PROD_W - 1) begin : g_top
			// Anything leaving the top column is beyond the kept width
			wallace_column i_col (
				.din  (col_din[c]),
				.cin  (col_cin[c]),
				.cout (),
				.carry(),
				.sum  (col_sum[c])
			);
		end else begin : g_body
			wallace_column i_col (
				.din  (col_din[c]),
				.cin  (col_cin[c]),
				.cout (col_cout[c]),
				.carry(col_carry[c]),
				.sum  (col_sum[c])
			);
		end
	end

	// Correction 31 fills the free low bit of the carry vector, 32 goes in on its own
	assign total = col_sum + {col_carry, neg[COL_CARRIES]} + PROD_W'(neg[BOOTH_ROWS-1]);
	assign product.full = total[2*XLEN-1:0];

	always_comb begin
		assert final ($isunknown({opa, opb, signed_a, signed_b, word}) || !$isunknown(product))
			else $error("mul_array: unknown product for known operands");
	end

endmodule

//--- mul_op_pkg.sv
package mul_op_pkg;

	// Low ops follow funct3, MULW takes the next free code
	typedef enum logic [2:0] {
		MUL    = 3'd0,
		MULH   = 3'd1,
		MULHSU = 3'd2,
		MULHU  = 3'd3,
		MULW   = 3'd4
	} mul_op_e;

	// Low half is the same either way, so MUL and MULW run signed
	function automatic logic op_signed_a(input mul_op_e op);
		return op != MULHU;
	endfunction

	function automatic logic op_signed_b(input mul_op_e op);
		return op inside {MUL, MULH, MULW};
	endfunction

	function automatic logic op_word(input mul_op_e op);
		return op == MULW;
	endfunction

	function automatic logic op_high(input mul_op_e op);
		return op inside {MULH, MULHSU, MULHU};
	endfunction

endpackage

//--- mul_pipe.sv
module mul_pipe (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           mul_valid,
	input  logic                           flush,
	input  mul_op_pkg::mul_op_e            op,
	input  logic [mul_types_pkg::XLEN-1:0] multiplicand,
	input  logic [mul_types_pkg::XLEN-1:0] multiplier,
	input  mul_types_pkg::mul_product_u    product,
	output logic [mul_types_pkg::XLEN-1:0] opa,
	output logic [mul_types_pkg::XLEN-1:0] opb,
	output logic                           signed_a,
	output logic                           signed_b,
	output logic                           word,
	output logic                           out_valid,
	output logic [mul_types_pkg::XLEN-1:0] result
);

	import mul_types_pkg::*;
	import mul_op_pkg::*;

	logic            s1_valid;
	mul_op_e         s1_op;
	logic [XLEN-1:0] sel_result;

	// Stage valids, flush drops whatever is in flight and the incoming request
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= mul_valid & ~flush;
			out_valid <= s1_valid & ~flush;
		end
	end

	// Stage 1 payload
	always_ff @(posedge clk) begin
		if (mul_valid) begin
			s1_op <= op;
			opa   <= multiplicand;
			opb   <= multiplier;
		end
	end

	assign signed_a = op_signed_a(s1_op);
	assign signed_b = op_signed_b(s1_op);
	assign word     = op_word(s1_op);

	always_comb begin
		if (op_word(s1_op))
			sel_result = {{(XLEN/2){product.half.lo[XLEN/2-1]}}, product.half.lo[XLEN/2-1:0]};
		else if (op_high(s1_op))
			sel_result = product.half.hi;
		else
			sel_result = product.half.lo;
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			result <= sel_result; // Held until the next request reaches stage 2
	end

	// A flush empties both stages, so nothing leaves for two cycles
	a_no_out_after_flush: assert property (
		@(posedge clk) disable iff (reset) flush |=> !out_valid ##1 !out_valid
	) else $error("mul_pipe: out_valid within two cycles after flush");

	a_legal_op: assert property (
		@(posedge clk) disable iff (reset)
		s1_valid |-> s1_op inside {MUL, MULH, MULHSU, MULHU, MULW}
	) else $error("mul_pipe: illegal op in stage 1");

endmodule

//--- mul_types_pkg.sv
package mul_types_pkg;

	localparam int XLEN = 64;

	// Two guard bits above the word keep unsigned operands positive in the array
	localparam int EXT_W = XLEN + 2;

	localparam int PROD_W = 2 * EXT_W;           // Full width of the Booth rows
	localparam int BOOTH_ROWS = EXT_W / 2;       // One radix-4 digit per row
	localparam int COL_CARRIES = BOOTH_ROWS - 2; // Full adders per column

	// Written whole by the array, read as halves when the result is picked
	typedef union packed {
		logic [2*XLEN-1:0] full;
		struct packed {
			logic [XLEN-1:0] hi;
			logic [XLEN-1:0] lo;
		} half;
	} mul_product_u;

endpackage

//--- mul_unit.sv
module mul_unit (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           mul_valid,
	input  logic                           flush,
	input  mul_op_pkg::mul_op_e            op,
	input  logic [mul_types_pkg::XLEN-1:0] multiplicand,
	input  logic [mul_types_pkg::XLEN-1:0] multiplier,
	output logic                           out_valid,
	output logic [mul_types_pkg::XLEN-1:0] result
);

	import mul_types_pkg::*;

	logic [XLEN-1:0] opa;
	logic [XLEN-1:0] opb;
	logic            signed_a;
	logic            signed_b;
	logic            word;
	mul_product_u    product;

	mul_pipe i_pipe (
		.clk         (clk),
		.reset       (reset),
		.mul_valid   (mul_valid),
		.flush       (flush),
		.op          (op),
		.multiplicand(multiplicand),
		.multiplier  (multiplier),
		.product     (product),
		.opa         (opa),
		.opb         (opb),
		.signed_a    (signed_a),
		.signed_b    (signed_b),
		.word        (word),
		.out_valid   (out_valid),
		.result      (result)
	);

	// Combinational, settles between the two pipeline registers
	mul_array i_array (
		.opa     (opa),
		.opb     (opb),
		.signed_a(signed_a),
		.signed_b(signed_b),
		.word    (word),
		.product (product)
	);

endmodule

//--- tb_mul_unit.sv
module tb_mul_unit;

	timeunit 1ns;
	timeprecision 1ps;

	import mul_op_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int CORNER_REQS  = 103;
	localparam int RANDOM_REQS  = 300;
	localparam int GAP_REQS     = 16;
	localparam int FLUSH_REQS   = 4;
	localparam int TOTAL_REQS   = CORNER_REQS + RANDOM_REQS + GAP_REQS + FLUSH_REQS;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQS + 100;

	logic        clk = 1'b0;
	logic        reset;
	logic        mul_valid;
	logic        flush;
	mul_op_e     op;
	logic [63:0] multiplicand;
	logic [63:0] multiplier;
	logic        out_valid;
	logic [63:0] result;

	logic [63:0] exp_q [$];
	logic [31:0] rng_state = 32'h38a59eac;
	int          errors = 0;
	int          pulses = 0;

	// Request history seen by the monitor, one entry per falling edge
	logic mv_d1 = 1'b0;
	logic mv_d2 = 1'b0;
	logic kill_d1 = 1'b0;
	logic kill_d2 = 1'b0;

	mul_unit i_dut (
		.clk         (clk),
		.reset       (reset),
		.mul_valid   (mul_valid),
		.flush       (flush),
		.op          (op),
		.multiplicand(multiplicand),
		.multiplier  (multiplier),
		.out_valid   (out_valid),
		.result      (result)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi, lo};
	endfunction

	// Full 128-bit product of the extended operands, then the result pick
	function automatic logic [63:0] expected_result(input mul_op_e o, input logic [63:0] a,
		input logic [63:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		ea = op_signed_a(o) ? {{64{a[63]}}, a} : {64'd0, a};
		eb = op_signed_b(o) ? {{64{b[63]}}, b} : {64'd0, b};
		p  = ea * eb;
		if (op_word(o))
			return {{32{p[31]}}, p[31:0]};
		else if (op_high(o))
			return p[127:64];
		else
			return p[63:0];
	endfunction

	task automatic issue(input mul_op_e o, input logic [63:0] a, input logic [63:0] b,
		input logic keep, input logic fl);
		@(posedge clk);
		mul_valid    <= 1'b1;
		flush        <= fl;
		op           <= o;
		multiplicand <= a;
		multiplier   <= b;
		if (keep)
			exp_q.push_back(expected_result(o, a, b));
	endtask

	task automatic issue_random(input logic keep);
		mul_op_e     o;
		logic [63:0] a;
		logic [63:0] b;
		o = mul_op_e'(next_rand() % 5);
		a = rand64();
		b = rand64();
		issue(o, a, b, keep, 1'b0);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		mul_valid <= 1'b0;
		flush     <= 1'b0;
	endtask

	// Wait until every expected result is out and nothing is left in flight
	task automatic drain();
		@(posedge clk);
		while (exp_q.size() != 0 || mv_d1 || mv_d2)
			@(posedge clk);
	endtask

	task automatic check_pulses(input int base, input int want);
		if (pulses - base != want) begin
			$display("Mismatch at %0t: out_valid pulses expected %0d actual %0d",
				$time, want, pulses - base);
			errors++;
		end
	endtask

	task automatic check_reset();
		repeat (20) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				$display("Error at %0t: out_valid is not low after reset", $time);
				errors++;
			end
		end
	endtask

	task automatic check_mul_corners();
		logic [63:0] cv [10];
		int          base;
		cv[0] = 64'h0000_0000_0000_0000;
		cv[1] = 64'h0000_0000_0000_0001;
		cv[2] = 64'hffff_ffff_ffff_ffff;
		cv[3] = 64'h8000_0000_0000_0000;
		cv[4] = 64'h7fff_ffff_ffff_ffff;
		cv[5] = 64'h0000_0000_7fff_ffff;
		cv[6] = 64'h0000_0000_8000_0000;
		cv[7] = 64'h0000_0000_ffff_ffff;
		cv[8] = 64'hffff_ffff_0000_0000;
		cv[9] = 64'ha5a5_a5a5_8000_0001; // Upper half must not matter for MULW
		base = pulses;
		for (int k = 0; k < 5; k++) begin
			for (int i = 0; i < 10; i++) begin
				issue(mul_op_e'(k), cv[i], cv[i], 1'b1, 1'b0);
				issue(mul_op_e'(k), cv[i], cv[(i + 3) % 10], 1'b1, 1'b0);
			end
		end
		issue(MULH, cv[3], cv[2], 1'b1, 1'b0);
		issue(MULHSU, cv[3], cv[2], 1'b1, 1'b0);
		issue(MULW, 64'hffff_0000_8000_0001, 64'h7777_0000_0000_0003, 1'b1, 1'b0);
		idle_cycle();
		drain();
		check_pulses(base, CORNER_REQS);
	endtask

	task automatic check_random();
		int base;
		base = pulses;
		repeat (RANDOM_REQS)
			issue_random(1'b1);
		idle_cycle();
		drain();
		check_pulses(base, RANDOM_REQS);
	endtask

	task automatic check_gaps();
		int base;
		int gap;
		base = pulses;
		repeat (GAP_REQS) begin
			gap = next_rand() % 4;
			repeat (gap)
				idle_cycle();
			issue_random(1'b1);
		end
		idle_cycle();
		drain();
		check_pulses(base, GAP_REQS);
	endtask

	// The first request is already at the output when flush rises, so it still leaves
	task automatic check_flush();
		int base;
		base = pulses;
		issue(MUL, rand64(), rand64(), 1'b1, 1'b0);
		issue(MULHU, rand64(), rand64(), 1'b0, 1'b0);
		issue(MULH, rand64(), rand64(), 1'b0, 1'b1);
		issue(MULW, rand64(), rand64(), 1'b1, 1'b0);
		idle_cycle();
		drain();
		check_pulses(base, 2);
	endtask

	// Latency and flush model plus the result compare
	always @(negedge clk) begin
		logic        exp_out;
		logic [63:0] exp_val;
		exp_out = mv_d2 & ~kill_d2 & ~kill_d1;
		if (out_valid !== exp_out) begin
			$display("Mismatch at %0t: out_valid expected %b actual %b", $time, exp_out,
				out_valid);
			errors++;
		end
		if (out_valid === 1'b1) begin
			pulses++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t: out_valid with no request outstanding", $time);
				errors++;
			end else begin
				exp_val = exp_q.pop_front();
				if (result !== exp_val) begin
					$display("Mismatch at %0t: result expected %h actual %h", $time,
						exp_val, result);
					errors++;
				end
			end
		end
		mv_d2   = mv_d1;
		kill_d2 = kill_d1;
		mv_d1   = mul_valid;
		kill_d1 = flush | reset;
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		$display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		reset        = 1'b1;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		op           = MUL;
		multiplicand = '0;
		multiplier   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		check_reset();
		check_mul_corners();
		check_random();
		check_gaps();
		check_flush();

		if (exp_q.size() != 0) begin
			$display("Error: %0d expected results never came out", exp_q.size());
			errors++;
		end
		$display("Errors counted: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- wallace_column.sv
module wallace_column (
	input  logic [32:0] din,
	input  logic [30:0] cin,
	output logic [30:0] cout,
	output logic        carry,
	output logic        sum
);

	logic [10:0] s1;
	logic [21:0] l2;
	logic [6:0]  s2;
	logic [14:0] l3;
	logic [4:0]  s3;
	logic [9:0]  l4;
	logic [2:0]  s4;
	logic [6:0]  l5;
	logic [1:0]  s5;
	logic [4:0]  l6;
	logic        s6;
	logic [3:0]  l7;
	logic        s7;
	logic [2:0]  l8;
	logic        s8;

	// 33 -> 11
	assign s1 = din[10:0] ^ din[21:11] ^ din[32:22];
	assign cout[10:0] = (din[10:0] & din[21:11]) | (din[10:0] & din[32:22])
		| (din[21:11] & din[32:22]);

	// 11 + 11 carries -> 8
	assign l2 = {s1, cin[10:0]};
	assign s2 = l2[6:0] ^ l2[13:7] ^ l2[20:14];
	assign cout[17:11] = (l2[6:0] & l2[13:7]) | (l2[6:0] & l2[20:14])
		| (l2[13:7] & l2[20:14]);

	// 8 + 7 -> 5
	assign l3 = {l2[21], s2, cin[17:11]};
	assign s3 = l3[4:0] ^ l3[9:5] ^ l3[14:10];
	assign cout[22:18] = (l3[4:0] & l3[9:5]) | (l3[4:0] & l3[14:10]) | (l3[9:5] & l3[14:10]);

	// 5 + 5 -> 4
	assign l4 = {s3, cin[22:18]};
	assign s4 = l4[2:0] ^ l4[5:3] ^ l4[8:6];
	assign cout[25:23] = (l4[2:0] & l4[5:3]) | (l4[2:0] & l4[8:6]) | (l4[5:3] & l4[8:6]);

	// 4 + 3 -> 3
	assign l5 = {l4[9], s4, cin[25:23]};
	assign s5 = l5[1:0] ^ l5[3:2] ^ l5[5:4];
	assign cout[27:26] = (l5[1:0] & l5[3:2]) | (l5[1:0] & l5[5:4]) | (l5[3:2] & l5[5:4]);

	assign l6 = {l5[6], s5, cin[27:26]};
	assign s6 = l6[0] ^ l6[1] ^ l6[2];
	assign cout[28] = (l6[0] & l6[1]) | (l6[0] & l6[2]) | (l6[1] & l6[2]);

	assign l7 = {l6[4:3], s6, cin[28]};
	assign s7 = l7[0] ^ l7[1] ^ l7[2];
	assign cout[29] = (l7[0] & l7[1]) | (l7[0] & l7[2]) | (l7[1] & l7[2]);

	assign l8 = {l7[3], s7, cin[29]};
	assign s8 = l8[0] ^ l8[1] ^ l8[2];
	assign cout[30] = (l8[0] & l8[1]) | (l8[0] & l8[2]) | (l8[1] & l8[2]);

	// Last pair, carry has the weight of the next column
	assign sum   = s8 ^ cin[30];
	assign carry = s8 & cin[30];

	// Lower column resolves from the same operands, so its carries must be known too
	always_comb begin
		assert final ($isunknown(din) || !$isunknown(cin))
			else $error("wallace_column: unknown carry group with known rows");
	end

endmodule
